// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opc_load     = 5'b00000,
        opc_misc_mem = 5'b00011,
        opc_op_imm   = 5'b00100,
        opc_auipc    = 5'b00101,
        opc_store    = 5'b01000,
        opc_op       = 5'b01100,
        opc_lui      = 5'b01101,
        opc_branch   = 5'b11000,
        opc_jalr     = 5'b11001,
        opc_jal      = 5'b11011,
        opc_system   = 5'b11100
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic {src1_rs1, src1_pc} alu_src1_e;
    typedef enum logic [1:0] {src2_rs2, src2_imm, src2_instlen} alu_src2_e;
    typedef enum logic [1:0] {rd_alu, rd_bus, rd_imm} rd_src_e;
    typedef enum logic {addr_pc, addr_alu} addr_src_e;

    typedef enum logic [4:0] {
        st_reset, st_fetch, st_decode,
        st_op, st_opimm,
        st_load1, st_load2, st_store1, st_store2,
        st_jal1, st_jal2, st_branch1, st_branch2,
        st_lui, st_auipc,
        st_regwrite_bus, st_regwrite_alu,
        st_pcnext, st_pcimm, st_pcregimm, st_pcupdate_fetch,
        st_halt
    } state_e;

    typedef enum logic {bus_read_word, bus_write_word} bus_op_e;

    typedef struct packed {
        logic        valid;
        bus_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_cmd_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [7:0]  dat;
        logic        cyc;
        logic        stb;
        logic        we;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic        funct7b5; // instr[30], sub / sra
        logic [31:0] imm;
    } dec_t;

    localparam logic [31:0] INSTLEN = 32'd4;

endpackage

`default_nettype wire

// File: cpu/alu.sv
`default_nettype none

module alu (
    input  logic                clk,
    input  logic                reset,
    input  logic                en,
    input  cpu_pkg::alu_op_e    op,
    input  cpu_pkg::alu_src1_e  src1,
    input  cpu_pkg::alu_src2_e  src2,
    input  logic [31:0]         rs1_val,
    input  logic [31:0]         rs2_val,
    input  logic [31:0]         pc,
    input  cpu_pkg::dec_t       dec,
    output logic [31:0]         result,
    output logic                eq,
    output logic                lt,
    output logic                ltu
);
    import cpu_pkg::*;

    logic [31:0] op1, op2, res;
    logic [4:0]  shamt;
    logic        lt_s, lt_u;

    assign op1 = (src1 == src1_pc) ? pc : rs1_val;

    always_comb begin
        case (src2)
            src2_imm:     op2 = dec.imm;
            src2_instlen: op2 = INSTLEN;
            default:      op2 = rs2_val;
        endcase
    end

    assign shamt = op2[4:0];
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    always_comb begin
        case (op)
            alu_sub:  res = op1 - op2;
            alu_sll:  res = op1 << shamt;
            alu_slt:  res = {31'd0, lt_s};
            alu_sltu: res = {31'd0, lt_u};
            alu_xor:  res = op1 ^ op2;
            alu_srl:  res = op1 >> shamt;
            alu_sra:  res = $signed(op1) >>> shamt;
            alu_or:   res = op1 | op2;
            alu_and:  res = op1 & op2;
            default:  res = op1 + op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            eq <= 1'b0;
            lt <= 1'b0;
            ltu <= 1'b0;
        end else if (en) begin
            result <= res;
            eq <= (op1 == op2);
            lt <= lt_s;
            ltu <= lt_u;
        end
    end

endmodule

`default_nettype wire

// File: cpu/registers.sv
`default_nettype none

module registers (
    input  logic              clk,
    input  cpu_pkg::dec_t     dec,
    input  logic              we,
    input  cpu_pkg::rd_src_e  rd_src,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       bus_rdata,
    output logic [31:0]       rs1_val,
    output logic [31:0]       rs2_val
);
    import cpu_pkg::*;

    logic [31:0] regs [1:31]; // x0 has no storage
    logic [31:0] wdata;

    always_comb begin
        case (rd_src)
            rd_bus:  wdata = bus_rdata;
            rd_imm:  wdata = dec.imm;
            default: wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (we && dec.rd != 5'd0)
            regs[dec.rd] <= wdata;
    end

    assign rs1_val = (dec.rs1 == 5'd0) ? 32'd0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == 5'd0) ? 32'd0 : regs[dec.rs2];

endmodule

`default_nettype wire

// File: cpu/decoder.sv
`default_nettype none

module decoder (
    input  logic [31:0]    instr,
    output cpu_pkg::dec_t  dec
);
    import cpu_pkg::*;

    opcode_e opc;

    assign opc = opcode_e'(instr[6:2]);

    always_comb begin
        dec.opcode = opc;
        dec.rd = instr[11:7];
        dec.funct3 = instr[14:12];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct7b5 = instr[30];
        case (opc)
            opc_store:
                dec.imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            opc_branch:
                dec.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            opc_lui, opc_auipc:
                dec.imm = {instr[31:12], 12'b0};
            opc_jal:
                dec.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            opc_op:
                dec.imm = '0; // no immediate
            default: // I-type, also load, jalr, system
                dec.imm = {{21{instr[31]}}, instr[30:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: cpu/cpu_control.sv
`default_nettype none

module cpu_control #(
    parameter logic [31:0] reset_vector = 32'd0
) (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::dec_t       dec,
    input  logic [31:0]         alu_result,
    input  logic                alu_eq,
    input  logic                alu_lt,
    input  logic                alu_ltu,
    input  logic                bus_done,
    input  logic [31:0]         bus_rdata,
    output logic [31:0]         instr,
    output logic [31:0]         pc,
    output logic                alu_en,
    output cpu_pkg::alu_op_e    alu_op,
    output cpu_pkg::alu_src1_e  src1,
    output cpu_pkg::alu_src2_e  src2,
    output logic                reg_we,
    output cpu_pkg::rd_src_e    rd_src,
    output cpu_pkg::bus_cmd_t   bus_cmd,
    input  logic [31:0]         rs2_val,
    output logic                halted
);
    import cpu_pkg::*;

    state_e    state;
    addr_src_e addr_sel;
    logic      fetch_done;
    logic      branch_taken;

    // funct3/funct7 to alu function, sub only for register ops
    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic f7b5,
                                         input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7b5) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return f7b5 ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = alu_eq;    // beq
            3'b001:  branch_taken = !alu_eq;   // bne
            3'b100:  branch_taken = alu_lt;
            3'b101:  branch_taken = !alu_lt;
            3'b110:  branch_taken = alu_ltu;
            3'b111:  branch_taken = !alu_ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    assign fetch_done = bus_done && (state == st_fetch || state == st_pcupdate_fetch);
    assign halted = (state == st_halt);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
            pc <= reset_vector;
        end else begin
            case (state)
                st_reset: state <= st_fetch;
                st_fetch: if (bus_done) state <= st_decode;
                st_decode: begin
                    case (dec.opcode)
                        opc_op:       state <= st_op;
                        opc_op_imm:   state <= st_opimm;
                        opc_load:     state <= st_load1;
                        opc_store:    state <= st_store1;
                        opc_jal:      state <= st_jal1;
                        opc_jalr:     state <= st_jal1;
                        opc_branch:   state <= st_branch1;
                        opc_lui:      state <= st_lui;
                        opc_auipc:    state <= st_auipc;
                        opc_misc_mem: state <= st_pcnext; // fence is a nop
                        opc_system:   state <= st_halt;
                        default:      state <= st_halt;
                    endcase
                end
                st_op, st_opimm, st_auipc: state <= st_regwrite_alu;
                st_load1: state <= st_load2;
                st_load2: if (bus_done) state <= st_regwrite_bus;
                st_store1: state <= st_store2;
                st_store2: if (bus_done) state <= st_pcnext;
                st_jal1: state <= st_jal2;
                st_jal2: state <= (dec.opcode == opc_jal) ? st_pcimm : st_pcregimm;
                st_branch1: state <= st_branch2;
                st_branch2: state <= branch_taken ? st_pcimm : st_pcnext;
                st_lui, st_regwrite_bus, st_regwrite_alu: state <= st_pcnext;
                st_pcnext, st_pcimm, st_pcregimm: state <= st_pcupdate_fetch;
                st_pcupdate_fetch: begin
                    if (bus_done) begin
                        pc <= bus_cmd.addr;
                        state <= st_decode;
                    end
                end
                st_halt: state <= st_halt; // until reset
                default: state <= st_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done)
            instr <= bus_rdata;
    end

    always_comb begin
        alu_en = 1'b0;
        alu_op = alu_add;
        src1 = src1_rs1;
        src2 = src2_rs2;
        reg_we = 1'b0;
        rd_src = rd_alu;
        addr_sel = addr_pc;
        bus_cmd.valid = 1'b0;
        bus_cmd.op = bus_read_word;
        bus_cmd.wdata = '0;
        case (state)
            st_fetch: bus_cmd.valid = 1'b1;
            st_op: begin
                alu_en = 1'b1;
                alu_op = funct_op(dec.funct3, dec.funct7b5, 1'b1);
            end
            st_opimm: begin
                alu_en = 1'b1;
                alu_op = funct_op(dec.funct3, dec.funct7b5, 1'b0);
                src2 = src2_imm;
            end
            st_load1, st_store1, st_pcregimm: begin // rs1 + imm
                alu_en = 1'b1;
                src2 = src2_imm;
            end
            st_load2: begin
                bus_cmd.valid = 1'b1;
                addr_sel = addr_alu;
            end
            st_store2: begin
                bus_cmd.valid = 1'b1;
                bus_cmd.op = bus_write_word;
                bus_cmd.wdata = rs2_val;
                addr_sel = addr_alu;
            end
            st_jal1, st_pcnext: begin // pc + 4
                alu_en = 1'b1;
                src1 = src1_pc;
                src2 = src2_instlen;
            end
            st_branch1: alu_en = 1'b1; // flags only
            st_auipc, st_pcimm: begin
                alu_en = 1'b1;
                src1 = src1_pc;
                src2 = src2_imm;
            end
            st_lui: begin
                reg_we = 1'b1;
                rd_src = rd_imm;
            end
            st_jal2, st_regwrite_alu: reg_we = 1'b1;
            st_regwrite_bus: begin
                reg_we = 1'b1;
                rd_src = rd_bus;
            end
            st_pcupdate_fetch: begin
                bus_cmd.valid = 1'b1;
                addr_sel = addr_alu;
            end
            default: ;
        endcase
        bus_cmd.addr = (addr_sel == addr_alu) ? alu_result : pc;
        if (state == st_pcupdate_fetch)
            bus_cmd.addr[0] = 1'b0; // jalr target lsb
    end

    // request held until the bus answers
    a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
        bus_cmd.valid && !bus_done |=> $stable(bus_cmd));

endmodule

`default_nettype wire

// File: verilog/bus_wb8.sv
`default_nettype none

module bus_wb8 (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::bus_cmd_t  cmd,
    output logic               done,
    output logic [31:0]        rdata,
    output cpu_pkg::wb_req_t   wb_req,
    input  cpu_pkg::wb_rsp_t   wb_rsp
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {wb_idle, wb_strobe, wb_gap} wb_state_e;

    wb_state_e  state;
    logic [1:0] byte_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wb_idle;
            byte_cnt <= 2'd0;
            done <= 1'b0;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                wb_idle: begin
                    // done still high means cmd is the finished one
                    if (cmd.valid && !done) begin
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we <= (cmd.op == bus_write_word);
                        wb_req.adr <= cmd.addr;
                        wb_req.dat <= cmd.wdata[7:0];
                        byte_cnt <= 2'd0;
                        state <= wb_strobe;
                    end
                end
                wb_strobe: begin
                    if (wb_rsp.ack) begin
                        wb_req.stb <= 1'b0;
                        if (!wb_req.we)
                            rdata <= {wb_rsp.dat, rdata[31:8]}; // little endian
                        if (byte_cnt == 2'd3) begin
                            wb_req.cyc <= 1'b0;
                            wb_req.we <= 1'b0;
                            done <= 1'b1;
                            state <= wb_idle;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            state <= wb_gap;
                        end
                    end
                end
                wb_gap: begin // one idle cycle between bytes
                    wb_req.stb <= 1'b1;
                    wb_req.adr <= wb_req.adr + 32'd1;
                    wb_req.dat <= cmd.wdata[{byte_cnt, 3'b000} +: 8];
                    state <= wb_strobe;
                end
                default: state <= wb_idle;
            endcase
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc);

    // slave may stall, request must not move
    a_adr_held: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

endmodule

`default_nettype wire

// File: cpu/cpu.sv
`default_nettype none

module cpu #(
    parameter logic [31:0] reset_vector = 32'd0
) (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::wb_rsp_t  wb_rsp,
    output cpu_pkg::wb_req_t  wb_req,
    output logic              halted
);
    import cpu_pkg::*;

    dec_t        dec;
    logic [31:0] instr, pc;
    logic [31:0] alu_result, rs1_val, rs2_val;
    logic        alu_en, alu_eq, alu_lt, alu_ltu;
    alu_op_e     alu_op;
    alu_src1_e   src1;
    alu_src2_e   src2;
    logic        reg_we;
    rd_src_e     rd_src;
    bus_cmd_t    bus_cmd;
    logic        bus_done;
    logic [31:0] bus_rdata;

    cpu_control #(
        .reset_vector(reset_vector)
    ) control_inst (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .alu_result (alu_result),
        .alu_eq     (alu_eq),
        .alu_lt     (alu_lt),
        .alu_ltu    (alu_ltu),
        .bus_done   (bus_done),
        .bus_rdata  (bus_rdata),
        .instr      (instr),
        .pc         (pc),
        .alu_en     (alu_en),
        .alu_op     (alu_op),
        .src1       (src1),
        .src2       (src2),
        .reg_we     (reg_we),
        .rd_src     (rd_src),
        .bus_cmd    (bus_cmd),
        .rs2_val    (rs2_val),
        .halted     (halted)
    );

    decoder dec_inst (
        .instr (instr),
        .dec   (dec)
    );

    registers reg_inst (
        .clk        (clk),
        .dec        (dec),
        .we         (reg_we),
        .rd_src     (rd_src),
        .alu_result (alu_result),
        .bus_rdata  (bus_rdata),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val)
    );

    alu alu_inst (
        .clk     (clk),
        .reset   (reset),
        .en      (alu_en),
        .op      (alu_op),
        .src1    (src1),
        .src2    (src2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .pc      (pc),
        .dec     (dec),
        .result  (alu_result),
        .eq      (alu_eq),
        .lt      (alu_lt),
        .ltu     (alu_ltu)
    );

    bus_wb8 bus_inst (
        .clk    (clk),
        .reset  (reset),
        .cmd    (bus_cmd),
        .done   (bus_done),
        .rdata  (bus_rdata),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

`default_nettype wire

// File: dv/wb_memory.sv
`default_nettype none

module wb_memory #(
    parameter int unsigned size = 4096,
    parameter logic [31:0] seed = 32'h28a98627
) (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::wb_req_t  wb_req,
    output cpu_pkg::wb_rsp_t  wb_rsp
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam int addr_bits = $clog2(size);

    logic [7:0]  mem [0:size-1];
    logic [31:0] rng;
    logic        busy;
    logic [1:0]  wait_cnt;
    logic        ack_q = 1'b0;
    logic [7:0]  dat_q = 8'h00;

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            busy <= 1'b0;
            rng <= seed;
        end else if (ack_q) begin
            ack_q <= 1'b0; // master drops stb on this edge
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy && rng[1:0] != 2'd0) begin
                busy <= 1'b1;
                wait_cnt <= rng[1:0] - 2'd1;
            end else if (busy && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                busy <= 1'b0;
                rng <= xorshift(rng); // next delay
                ack_q <= 1'b1;
                if (wb_req.we)
                    mem[wb_req.adr[addr_bits-1:0]] = wb_req.dat;
                dat_q <= mem[wb_req.adr[addr_bits-1:0]];
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_cpu.sv
`default_nettype none

module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam logic [31:0] reset_vector = 32'h0000_0100;
    localparam logic [31:0] data_base = 32'h0000_0800;
    // about 160 instructions in all, under 60 cycles each at worst ack delay
    localparam int max_cycles = 20000;

    localparam logic [6:0] lui_op = 7'b0110111;
    localparam logic [6:0] auipc_op = 7'b0010111;
    localparam logic [6:0] jal_op = 7'b1101111;
    localparam logic [6:0] jalr_op = 7'b1100111;
    localparam logic [6:0] branch_op = 7'b1100011;
    localparam logic [6:0] load_op = 7'b0000011;
    localparam logic [6:0] store_op = 7'b0100011;
    localparam logic [6:0] opimm_op = 7'b0010011;
    localparam logic [6:0] reg_op = 7'b0110011;
    localparam logic [31:0] fence_word = 32'h0ff0000f;
    localparam logic [31:0] ebreak_word = 32'h00100073;
    localparam logic [31:0] unknown_word = 32'h0000007b; // reserved major opcode

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        halted;
    int          cycle_count = 0;
    logic [31:0] prog [$];
    logic [31:0] expected [$]; // words stored at data_base, in order

    cpu #(
        .reset_vector(reset_vector)
    ) UUT (
        .clk    (clk),
        .reset  (reset),
        .wb_rsp (wb_rsp),
        .wb_req (wb_req),
        .halted (halted)
    );

    wb_memory #(
        .size(4096)
    ) ram (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "%s", what);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
            fail($sformatf("Timeout after %0d cycles, the core never halted", max_cycles));
    end

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], store_op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], branch_op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jal_op};
    endfunction

    function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] shift_arith(input logic [31:0] v, input logic [4:0] n);
        return $signed(v) >>> n;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {fill_byte(a[11:0] + 12'd3), fill_byte(a[11:0] + 12'd2),
                fill_byte(a[11:0] + 12'd1), fill_byte(a[11:0])};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {ram.mem[a + 3], ram.mem[a + 2], ram.mem[a + 1], ram.mem[a]};
    endfunction

    function automatic logic [31:0] next_pc();
        return reset_vector + 32'(4 * prog.size());
    endfunction

    task automatic clear_program();
        prog.delete();
        expected.delete();
    endtask

    // lui + addi, upper part rounded for the sign of the low 12 bits
    task automatic load_imm(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog.push_back(u_type(upper[31:12], rd, lui_op));
        prog.push_back(i_type(value[11:0], rd, 3'b000, rd, opimm_op));
    endtask

    task automatic store_result(input logic [4:0] rs, input logic [31:0] exp);
        prog.push_back(s_type(12'(4 * expected.size()), rs, 5'd10));
        expected.push_back(exp);
    endtask

    task automatic boot_program();
        int a;
        int k;
        reset = 1'b1;
        for (a = 0; a < 4096; a++)
            ram.mem[a] = fill_byte(a[11:0]);
        foreach (prog[i]) begin
            for (k = 0; k < 4; k++)
                ram.mem[reset_vector + 4 * i + k] = prog[i][8 * k +: 8];
        end
        repeat (8) tick();
        expect_eq("wb_req.cyc", wb_req.cyc, 1'b0);
        expect_eq("wb_req.stb", wb_req.stb, 1'b0);
        expect_eq("halted", halted, 1'b0);
        reset = 1'b0;
    endtask

    task automatic wait_halt();
        while (!halted)
            tick();
    endtask

    task automatic check_results();
        logic [31:0] addr;
        foreach (expected[i]) begin
            addr = data_base + 32'(4 * i);
            expect_eq($sformatf("mem[0x%03h]", addr), mem_word(addr), expected[i]);
        end
    endtask

    task automatic reset_fetch_test();
        clear_program();
        prog.push_back(ebreak_word);
        boot_program();
        while (!wb_req.stb)
            tick();
        expect_eq("wb_req.adr", wb_req.adr, reset_vector);
        expect_eq("wb_req.we", wb_req.we, 1'b0);
        wait_halt();
    endtask

    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] exp);
        prog.push_back(r_type(f7, 5'd2, 5'd1, f3, 5'd3, reg_op));
        store_result(5'd3, exp);
    endtask

    task automatic alu_imm(input logic [11:0] imm, input logic [2:0] f3, input logic [31:0] exp);
        prog.push_back(i_type(imm, 5'd1, f3, 5'd3, opimm_op));
        store_result(5'd3, exp);
    endtask

    task automatic alu_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a = 32'h8765_4321; // negative for slt and sra
        b = 32'h1234_5673; // only 5'd19 counts as shift
        sh = b[4:0];
        clear_program();
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        load_imm(5'd10, data_base);
        alu_reg(7'h00, 3'b000, a + b);
        alu_reg(7'h20, 3'b000, a - b);
        alu_reg(7'h00, 3'b001, a << sh);
        alu_reg(7'h00, 3'b010, {31'd0, $signed(a) < $signed(b)});
        alu_reg(7'h00, 3'b011, {31'd0, a < b});
        alu_reg(7'h00, 3'b100, a ^ b);
        alu_reg(7'h00, 3'b101, a >> sh);
        alu_reg(7'h20, 3'b101, shift_arith(a, sh));
        alu_reg(7'h00, 3'b110, a | b);
        alu_reg(7'h00, 3'b111, a & b);
        alu_imm(12'hffb, 3'b000, a + 32'hffff_fffb);
        alu_imm(12'h005, 3'b010, {31'd0, $signed(a) < 32'sd5});
        alu_imm(12'hfff, 3'b011, {31'd0, a < 32'hffff_ffff});
        alu_imm(12'h7f0, 3'b100, a ^ 32'h0000_07f0);
        alu_imm(12'h80f, 3'b110, a | 32'hffff_f80f);
        alu_imm(12'h0ff, 3'b111, a & 32'h0000_00ff);
        alu_imm(12'h007, 3'b001, a << 7);
        alu_imm(12'h007, 3'b101, a >> 7);
        alu_imm(12'h407, 3'b101, shift_arith(a, 5'd7));
        prog.push_back(ebreak_word);
        boot_program();
        wait_halt();
        check_results();
    endtask

    task automatic load_store_test();
        logic [31:0] value;
        value = 32'ha1b2_c3d4;
        clear_program();
        load_imm(5'd1, value);
        load_imm(5'd10, data_base);
        prog.push_back(s_type(12'd0, 5'd1, 5'd10));
        prog.push_back(fence_word);
        prog.push_back(i_type(12'd0, 5'd10, 3'b010, 5'd2, load_op));
        prog.push_back(s_type(12'd8, 5'd2, 5'd10));
        prog.push_back(i_type(12'd16, 5'd10, 3'b000, 5'd11, opimm_op));
        prog.push_back(i_type(12'hff0, 5'd11, 3'b010, 5'd3, load_op)); // -16
        prog.push_back(s_type(12'hffc, 5'd3, 5'd11)); // -4, lands at +12
        prog.push_back(ebreak_word);
        boot_program();
        wait_halt();
        expect_eq("mem[data_base]", ram.mem[data_base], value[7:0]);
        expect_eq("mem[data_base+1]", ram.mem[data_base + 1], value[15:8]);
        expect_eq("mem[data_base+2]", ram.mem[data_base + 2], value[23:16]);
        expect_eq("mem[data_base+3]", ram.mem[data_base + 3], value[31:24]);
        expect_eq("mem[data_base+4]", mem_word(data_base + 4), fill_word(data_base + 4));
        expect_eq("mem[data_base+8]", mem_word(data_base + 8), value);
        expect_eq("mem[data_base+12]", mem_word(data_base + 12), value);
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [31:0] v1,
                               input logic [31:0] v2);
        logic [11:0] mark;
        mark = 12'h100 + 12'(2 * expected.size());
        prog.push_back(b_type(13'd12, rs2, rs1, f3));
        prog.push_back(i_type(mark, 5'd0, 3'b000, 5'd5, opimm_op)); // not taken
        prog.push_back(j_type(21'd8, 5'd0));
        prog.push_back(i_type(mark + 12'd1, 5'd0, 3'b000, 5'd5, opimm_op)); // taken
        store_result(5'd5, {20'd0, branch_rule(f3, v1, v2) ? mark + 12'd1 : mark});
    endtask

    task automatic branch_test();
        logic [31:0] neg;
        logic [31:0] pos;
        neg = 32'hffff_fffe;
        pos = 32'd3;
        clear_program();
        load_imm(5'd1, neg);
        load_imm(5'd2, pos);
        load_imm(5'd10, data_base);
        branch_case(3'b000, 5'd2, 5'd2, pos, pos);
        branch_case(3'b000, 5'd1, 5'd2, neg, pos);
        branch_case(3'b001, 5'd1, 5'd2, neg, pos);
        branch_case(3'b001, 5'd2, 5'd2, pos, pos);
        branch_case(3'b100, 5'd1, 5'd2, neg, pos);
        branch_case(3'b100, 5'd2, 5'd1, pos, neg);
        branch_case(3'b101, 5'd2, 5'd1, pos, neg);
        branch_case(3'b101, 5'd1, 5'd2, neg, pos);
        branch_case(3'b110, 5'd2, 5'd1, pos, neg);
        branch_case(3'b110, 5'd1, 5'd2, neg, pos);
        branch_case(3'b111, 5'd1, 5'd2, neg, pos);
        branch_case(3'b111, 5'd2, 5'd1, pos, neg);
        prog.push_back(ebreak_word);
        boot_program();
        wait_halt();
        check_results();
    endtask

    task automatic jump_test();
        logic [31:0] jal_pc;
        logic [31:0] jalr_pc;
        logic [31:0] auipc_pc;
        clear_program();
        load_imm(5'd10, data_base);
        prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd6, opimm_op));
        jal_pc = next_pc();
        prog.push_back(j_type(21'd12, 5'd1));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd6, opimm_op)); // skipped
        prog.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd6, opimm_op));
        store_result(5'd1, jal_pc + 32'd4);
        prog.push_back(u_type(20'd0, 5'd7, auipc_op));
        jalr_pc = next_pc();
        prog.push_back(i_type(12'd17, 5'd7, 3'b000, 5'd2, jalr_op)); // odd target
        prog.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd6, opimm_op)); // skipped
        prog.push_back(i_type(12'd4, 5'd0, 3'b000, 5'd6, opimm_op));
        store_result(5'd2, jalr_pc + 32'd4);
        store_result(5'd6, 32'd0);
        prog.push_back(u_type(20'habcde, 5'd3, lui_op));
        store_result(5'd3, 32'habcd_e000);
        auipc_pc = next_pc();
        prog.push_back(u_type(20'h12345, 5'd4, auipc_op));
        store_result(5'd4, auipc_pc + 32'h1234_5000);
        prog.push_back(ebreak_word);
        boot_program();
        wait_halt();
        check_results();
    endtask

    task automatic halt_test(input logic [31:0] halt_word);
        clear_program();
        load_imm(5'd10, data_base);
        prog.push_back(i_type(12'h055, 5'd0, 3'b000, 5'd5, opimm_op));
        prog.push_back(halt_word);
        prog.push_back(s_type(12'd0, 5'd5, 5'd10)); // must never run
        boot_program();
        wait_halt();
        repeat (100) begin
            tick();
            if (wb_req.cyc)
                fail($sformatf("Bus cycle started after halt on 0x%08h", halt_word));
            expect_eq("halted", halted, 1'b1);
        end
        expect_eq("mem[data_base]", mem_word(data_base), fill_word(data_base));
    endtask

    initial begin
        reset = 1'b1;
        reset_fetch_test();
        alu_test();
        load_store_test();
        branch_test();
        jump_test();
        halt_test(ebreak_word);
        halt_test(unknown_word);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: riscv_wb8.f
common/cpu_pkg.sv
cpu/alu.sv
cpu/registers.sv
cpu/decoder.sv
cpu/cpu_control.sv
verilog/bus_wb8.sv
cpu/cpu.sv
dv/wb_memory.sv
dv/tb_cpu.sv
